// File: verification/core_vectors.txt
# I <byte address> <instruction>, E <expected tohost value in order>,
# M <data byte address> <expected final word>
I 00 00500093
I 04 ffd00113
I 08 002081b3
I 0c 51e19073
I 10 40208233
I 14 00421213
I 18 51e21073
I 1c 123452b7
I 20 6782e293
I 24 10502023
I 28 102002a3
I 2c 10500383
I 30 51e39073
I 34 10504403
I 38 007404b3
I 3c 51e49073
I 40 10002503
I 44 51e51073
I 48 00208463
I 4c 00114663
I 50 51e09073
I 54 51e09073
I 58 00116463
I 5c 00c005ef
I 60 51e09073
I 64 51e09073
I 68 51e59073
I 6c 01c58667
I 70 51e09073
I 74 51e09073
I 78 51e09073
I 7c 51e61073
I 80 10902423
I 84 00100693
I 88 51e69073
I 8c 0000006f
E 00000002
E 00000080
E fffffffd
E 000000fa
E 12345678
E 00000060
E 00000070
E 00000001
M 100 12345678
M 104 0000fd00
M 108 000000fa

// File: filelist.f
design/rv_pkg.sv
design/decode_bus_if.sv
design/decode_read.sv
design/regfile.sv
design/execute.sv
design/writeback.sv
design/pipeline_control.sv
design/riscv151.sv
verification/clk_gen.sv
verification/core_chk.sv
verification/core_tb.sv

// File: Bender.yml
package:
  name: riscv151_core

sources:
  - files:
      - design/rv_pkg.sv
      - design/decode_bus_if.sv
      - design/decode_read.sv
      - design/regfile.sv
      - design/execute.sv
      - design/writeback.sv
      - design/pipeline_control.sv
      - design/riscv151.sv
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/core_chk.sv
      - verification/core_tb.sv

// File: verification/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  localparam int          mem_words      = 256;
  localparam int          timeout_cycles = 5000;
  localparam logic [31:0] sentinel       = 32'd1;
  localparam logic [31:0] lfsr_taps      = 32'h8020_0003;
  localparam logic [31:0] lfsr_seed      = 32'd87299;

  wire                clk;
  wire                rst;
  rv_pkg::word_t      icache_addr;
  rv_pkg::word_t      icache_dout;
  rv_pkg::word_t      dcache_addr;
  rv_pkg::word_t      dcache_din;
  rv_pkg::word_t      dcache_dout;
  rv_pkg::word_t      csr;
  rv_pkg::byte_en_t   dcache_we;
  logic               icache_re;
  logic               dcache_re;
  logic               stall;

  rv_pkg::word_t      rom [mem_words];
  rv_pkg::word_t      ram [mem_words];
  rv_pkg::word_t      exp_tohost [$];
  rv_pkg::word_t      mem_addr [$];
  rv_pkg::word_t      mem_data [$];
  int                 error_count;
  int                 check_count;
  logic               aborted;
  logic               random_mode;
  logic [31:0]        lfsr;
  logic               first_bit;

  clk_gen u_clk (.clk(clk), .rst(rst));

  riscv151 i_dut (
    .clk         (clk),
    .rst         (rst),
    .icache_addr (icache_addr),
    .icache_re   (icache_re),
    .icache_dout (icache_dout),
    .dcache_addr (dcache_addr),
    .dcache_re   (dcache_re),
    .dcache_we   (dcache_we),
    .dcache_din  (dcache_din),
    .dcache_dout (dcache_dout),
    .stall       (stall),
    .csr         (csr)
  );

  // Both memories answer one cycle after an enabled read; stalled edges write nothing.
  always @(posedge clk) begin
    if (icache_re) icache_dout <= rom[icache_addr[9:2]];
    if (dcache_re) dcache_dout <= ram[dcache_addr[9:2]];
    if (!stall) begin
      if (dcache_we[0]) ram[dcache_addr[9:2]][7:0]   <= dcache_din[7:0];
      if (dcache_we[1]) ram[dcache_addr[9:2]][15:8]  <= dcache_din[15:8];
      if (dcache_we[2]) ram[dcache_addr[9:2]][23:16] <= dcache_din[23:16];
      if (dcache_we[3]) ram[dcache_addr[9:2]][31:24] <= dcache_din[31:24];
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ lfsr_taps;
    end
    return n;
  endfunction

  // Stall is high when two fresh random bits are both one.
  always @(posedge clk) begin
    #1;
    if (random_mode) begin
      first_bit = lfsr[0];
      lfsr = lfsr_step(lfsr);
      stall = first_bit & lfsr[0];
      lfsr = lfsr_step(lfsr);
    end else begin
      stall = 1'b0;
    end
  end

  task automatic check_value(input string name, input rv_pkg::word_t expected,
                             input rv_pkg::word_t actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic load_vectors;
    int fd;
    int code;
    int i;
    string line;
    byte kind;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    // Unused ROM words are NOPs whose immediate is the word index.
    for (i = 0; i < mem_words; i++) begin
      rom[i] = {12'(i), 20'h00013};
    end
    fd = $fopen("verification/core_vectors.txt", "r");
    if (fd == 0) begin
      error_count++;
      aborted = 1'b1;
      $display("Could not open the vector file verification/core_vectors.txt.");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%c %h %h", kind, a, b);
          case (kind)
            "I": rom[a[9:2]] = b;
            "E": exp_tohost.push_back(a);
            "M": begin
              mem_addr.push_back(a);
              mem_data.push_back(b);
            end
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_program(input string tag);
    int cycles;
    int exp_idx;
    int i;
    rv_pkg::word_t last;
    logic done;
    u_clk.assert_reset();
    for (i = 0; i < mem_words; i++) begin
      ram[i] = '0;
    end
    repeat (3) @(negedge clk);
    check_value({tag, " reset csr"}, '0, csr);
    check_value({tag, " reset dcache_we"}, '0, rv_pkg::word_t'(dcache_we));
    check_value({tag, " reset dcache_re"}, '0, rv_pkg::word_t'(dcache_re));
    check_value({tag, " reset icache_addr"}, rv_pkg::reset_pc, icache_addr);
    u_clk.release_reset();
    cycles = 0;
    exp_idx = 0;
    last = '0;
    done = 1'b0;
    while (!done && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
      if (csr !== last) begin
        if (exp_idx < exp_tohost.size()) begin
          check_value($sformatf("%s tohost %0d", tag, exp_idx), exp_tohost[exp_idx], csr);
        end else begin
          error_count++;
          $display("%s: tohost changed to %h after the expected sequence ended", tag, csr);
        end
        exp_idx++;
        last = csr;
        done = (csr == sentinel);
      end
    end
    if (!done) begin
      error_count++;
      aborted = 1'b1;
      $display("%s: program did not finish within %0d cycles", tag, timeout_cycles);
    end else begin
      check_value({tag, " tohost count"}, exp_tohost.size(), exp_idx);
      for (i = 0; i < mem_addr.size(); i++) begin
        check_value($sformatf("%s mem %h", tag, mem_addr[i]), mem_data[i],
                    ram[mem_addr[i][9:2]]);
      end
    end
  endtask

  initial begin
    stall = 1'b0;
    random_mode = 1'b0;
    lfsr = lfsr_seed;
    icache_dout = '0;
    dcache_dout = '0;
    error_count = 0;
    check_count = 0;
    aborted = 1'b0;
    load_vectors();
    if (!aborted) begin
      run_program("no_stall");
    end
    if (!aborted) begin
      random_mode = 1'b1;
      run_program("random_stall");
      random_mode = 1'b0;
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module core_chk (
  input wire                    clk,
  input wire                    rst,
  input wire                    stall,
  input wire                    dcache_re,
  input wire rv_pkg::byte_en_t  dcache_we,
  input wire rv_pkg::word_t     icache_addr,
  input wire rv_pkg::word_t     csr
);

  // A load and a store never share stage 3.
  assert property (@(posedge clk) disable iff (rst) !((|dcache_we) && dcache_re))
    else $error("dcache_we and dcache_re are high together");

  assert property (@(posedge clk) $fell(rst) |-> dcache_we == '0)
    else $error("dcache_we is set in the first cycle after reset");

  assert property (@(posedge clk) disable iff (rst) stall |-> $stable(icache_addr))
    else $error("icache_addr moved while stall was high");

  // The tohost register only loads on an unstalled edge.
  assert property (@(posedge clk) disable iff (rst) stall |=> $stable(csr))
    else $error("csr changed across a stalled edge");

endmodule

bind riscv151 core_chk i_chk (
  .clk         (clk),
  .rst         (rst),
  .stall       (stall),
  .dcache_re   (dcache_re),
  .dcache_we   (dcache_we),
  .icache_addr (icache_addr),
  .csr         (csr)
);

`default_nettype wire

// File: verification/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running 8 ns clock and a reset that the testbench can raise again.
module clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
  end

  always #4 clk = ~clk;

  task automatic assert_reset;
    @(posedge clk);
    #1;
    rst = 1'b1;
  endtask

  // Together with the two edges the caller waits through, reset lasts four cycles.
  task automatic release_reset;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

endmodule

`default_nettype wire

// File: design/riscv151.sv
`timescale 1ns/1ps
`default_nettype none

module riscv151 (
  input  wire                   clk,
  input  wire                   rst,
  output rv_pkg::word_t         icache_addr,
  output logic                  icache_re,
  input  wire  rv_pkg::word_t   icache_dout,
  output rv_pkg::word_t         dcache_addr,
  output logic                  dcache_re,
  output rv_pkg::byte_en_t      dcache_we,
  output rv_pkg::word_t         dcache_din,
  input  wire  rv_pkg::word_t   dcache_dout,
  input  wire                   stall,
  output rv_pkg::word_t         csr
);

  rv_pkg::word_t    fetch_pc;
  rv_pkg::word_t    next_pc;
  rv_pkg::word_t    jump_target;
  rv_pkg::word_t    rd1;
  rv_pkg::word_t    rd2;
  rv_pkg::word_t    wb_value;
  rv_pkg::reg_idx_t rs1_addr;
  rv_pkg::reg_idx_t rs2_addr;
  logic             do_jump_ex;
  logic             internal_stall;
  logic             bubble;
  logic             pause;

  decode_bus_if dec_bus ();
  exec_bus_if   ex_bus ();

  assign icache_addr = next_pc;
  assign icache_re   = 1'b1;
  assign dcache_addr = {ex_bus.result[31:2], 2'b00};

  pipeline_control u_control (
    .clk            (clk),
    .rst            (rst),
    .stall          (stall),
    .pause          (pause),
    .ex             (ex_bus),
    .jump_target    (jump_target),
    .do_jump_ex     (do_jump_ex),
    .fetch_pc       (fetch_pc),
    .next_pc        (next_pc),
    .internal_stall (internal_stall),
    .bubble         (bubble)
  );

  decode_read u_decode (
    .clk            (clk),
    .rst            (rst),
    .instr          (icache_dout),
    .fetch_pc       (fetch_pc),
    .internal_stall (internal_stall),
    .bubble         (bubble),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .bus            (dec_bus)
  );

  // Writes wait for the last cycle of stage 3, when a load's data is valid.
  regfile u_regfile (
    .clk  (clk),
    .hold (internal_stall),
    .ra1  (rs1_addr),
    .ra2  (rs2_addr),
    .we   (ex_bus.reg_we && !internal_stall),
    .wa   (ex_bus.rd),
    .wd   (wb_value),
    .rd1  (rd1),
    .rd2  (rd2)
  );

  execute u_execute (
    .clk            (clk),
    .rst            (rst),
    .internal_stall (internal_stall),
    .bubble         (bubble),
    .dec            (dec_bus),
    .rd1            (rd1),
    .rd2            (rd2),
    .wb_value       (wb_value),
    .wb             (ex_bus),
    .out_bus        (ex_bus),
    .jump_target    (jump_target),
    .do_jump        (do_jump_ex)
  );

  writeback u_writeback (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .bus         (ex_bus),
    .dcache_dout (dcache_dout),
    .wb_value    (wb_value),
    .dcache_din  (dcache_din),
    .dcache_we   (dcache_we),
    .dcache_re   (dcache_re),
    .pause       (pause)
  );

  // The tohost register, written by CSRRW when it leaves stage 3.
  always_ff @(posedge clk) begin
    if (rst) begin
      csr <= '0;
    end else if (ex_bus.csr_write && !internal_stall) begin
      csr <= wb_value;
    end
  end

endmodule

`default_nettype wire

// File: design/pipeline_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   stall,
  input  wire                   pause,
  exec_bus_if.stage3            ex,
  input  wire  rv_pkg::word_t   jump_target,
  input  wire                   do_jump_ex,
  output rv_pkg::word_t         fetch_pc,
  output rv_pkg::word_t         next_pc,
  output logic                  internal_stall,
  output logic                  bubble
);

  rv_pkg::word_t target_q;

  assign internal_stall = stall || pause;

  // A jump redirects fetch once it has reached stage 3, so the bubble and the
  // redirect come from the same flag.
  assign bubble = ex.do_jump;

  // The target leaves execute together with the jump flag.
  always_ff @(posedge clk) begin
    if (!internal_stall && do_jump_ex) begin
      target_q <= jump_target;
    end
  end

  // While stalled the current address is requested again, so the word on the
  // instruction port does not change.
  always_comb begin
    if (rst) begin
      next_pc = rv_pkg::reset_pc;
    end else if (internal_stall) begin
      next_pc = fetch_pc;
    end else if (ex.do_jump) begin
      next_pc = target_q;
    end else begin
      next_pc = fetch_pc + 32'd4;
    end
  end

  // fetch_pc is the address of the word now arriving from instruction memory.
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc <= rv_pkg::reset_pc;
    end else begin
      fetch_pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: design/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   stall,
  exec_bus_if.stage3            bus,
  input  wire  rv_pkg::word_t   dcache_dout,
  output rv_pkg::word_t         wb_value,
  output rv_pkg::word_t         dcache_din,
  output rv_pkg::byte_en_t      dcache_we,
  output logic                  dcache_re,
  output logic                  pause
);

  logic          paused_q;
  logic [1:0]    offset;
  logic [7:0]    load_byte;
  rv_pkg::word_t load_value;

  assign offset = bus.result[1:0];

  // The first cycle of a load waits for the synchronous read data.
  assign pause = bus.mem_rr && !paused_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      paused_q <= 1'b0;
    end else if (!stall) begin
      paused_q <= pause;
    end
  end

  assign dcache_re = bus.mem_rr;

  // Byte stores put the byte in every lane and let the enables pick one.
  assign dcache_din = (bus.funct3 == rv_pkg::f3_byte) ? {4{bus.store_data[7:0]}}
                                                      : bus.store_data;

  always_comb begin
    dcache_we = '0;
    if (bus.mem_we) begin
      case (bus.funct3)
        rv_pkg::f3_byte: dcache_we = rv_pkg::byte_en_t'(4'b0001 << offset);
        rv_pkg::f3_word: dcache_we = 4'b1111;
        default:         dcache_we = '0;
      endcase
    end
  end

  assign load_byte = dcache_dout[{offset, 3'b000} +: 8];

  always_comb begin
    case (bus.funct3)
      rv_pkg::f3_byte:   load_value = {{24{load_byte[7]}}, load_byte};
      rv_pkg::f3_byte_u: load_value = {24'b0, load_byte};
      rv_pkg::f3_word:   load_value = dcache_dout;
      default:           load_value = dcache_dout;
    endcase
  end

  assign wb_value = bus.mem_rr ? load_value : bus.result;

endmodule

`default_nettype wire

// File: design/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   internal_stall,
  input  wire                   bubble,
  decode_bus_if.stage2          dec,
  input  wire  rv_pkg::word_t   rd1,
  input  wire  rv_pkg::word_t   rd2,
  input  wire  rv_pkg::word_t   wb_value,
  exec_bus_if.stage3            wb,
  exec_bus_if.stage2            out_bus,
  output rv_pkg::word_t         jump_target,
  output logic                  do_jump
);

  rv_pkg::word_t src1;
  rv_pkg::word_t src2;
  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_y;
  rv_pkg::word_t result;
  logic          taken;
  logic          fwd_ok;

  // Stage 3 is the only producer whose value has not reached the register file.
  assign fwd_ok = wb.reg_we && (wb.rd != '0);
  assign src1   = (fwd_ok && wb.rd == dec.rs1) ? wb_value : rd1;
  assign src2   = (fwd_ok && wb.rd == dec.rs2) ? wb_value : rd2;

  assign op_a = dec.a_sel ? dec.pc : src1;
  assign op_b = dec.b_sel ? dec.imm : src2;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add:    alu_y = op_a + op_b;
      rv_pkg::alu_sub:    alu_y = op_a - op_b;
      rv_pkg::alu_sll:    alu_y = op_a << op_b[4:0];
      rv_pkg::alu_slt:    alu_y = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
      rv_pkg::alu_sltu:   alu_y = rv_pkg::word_t'(op_a < op_b);
      rv_pkg::alu_xor:    alu_y = op_a ^ op_b;
      rv_pkg::alu_srl:    alu_y = op_a >> op_b[4:0];
      rv_pkg::alu_sra:    alu_y = $signed(op_a) >>> op_b[4:0];
      rv_pkg::alu_or:     alu_y = op_a | op_b;
      rv_pkg::alu_and:    alu_y = op_a & op_b;
      rv_pkg::alu_copy_b: alu_y = op_b;
      default:            alu_y = op_a + op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      rv_pkg::f3_beq:  taken = (src1 == src2);
      rv_pkg::f3_bne:  taken = (src1 != src2);
      rv_pkg::f3_blt:  taken = ($signed(src1) < $signed(src2));
      rv_pkg::f3_bge:  taken = ($signed(src1) >= $signed(src2));
      rv_pkg::f3_bltu: taken = (src1 < src2);
      rv_pkg::f3_bgeu: taken = (src1 >= src2);
      default:         taken = 1'b0;
    endcase
  end

  assign do_jump = dec.is_jump || (dec.is_branch && taken);

  // JALR is the only jump based on rs1 (a_sel low), and it drops bit 0 of the sum.
  assign jump_target = {alu_y[31:1], alu_y[0] & dec.a_sel};

  // Jumps write the link address instead of the computed target.
  assign result = dec.is_jump ? dec.pc + 32'd4 : alu_y;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_bus.reg_we    <= 1'b0;
      out_bus.mem_we    <= 1'b0;
      out_bus.mem_rr    <= 1'b0;
      out_bus.csr_write <= 1'b0;
      out_bus.do_jump   <= 1'b0;
    end else if (!internal_stall) begin
      out_bus.reg_we    <= dec.reg_we && !bubble;
      out_bus.mem_we    <= dec.mem_we && !bubble;
      out_bus.mem_rr    <= dec.mem_rr && !bubble;
      out_bus.csr_write <= dec.csr_write && !bubble;
      out_bus.do_jump   <= do_jump && !bubble;
    end
  end

  always_ff @(posedge clk) begin
    if (!internal_stall) begin
      out_bus.result     <= result;
      out_bus.store_data <= src2;
      out_bus.funct3     <= dec.funct3;
      out_bus.rd         <= dec.rd;
    end
  end

endmodule

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire                     clk,
  input  wire                     hold,
  input  wire  rv_pkg::reg_idx_t  ra1,
  input  wire  rv_pkg::reg_idx_t  ra2,
  input  wire                     we,
  input  wire  rv_pkg::reg_idx_t  wa,
  input  wire  rv_pkg::word_t     wd,
  output rv_pkg::word_t           rd1,
  output rv_pkg::word_t           rd2
);

  rv_pkg::word_t regs [rv_pkg::reg_count];

  // A write landing on the same edge as the read is seen by the read.
  function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t ra);
    rv_pkg::word_t value;
    if (ra == '0) begin
      value = '0;
    end else if (we && wa == ra) begin
      value = wd;
    end else begin
      value = regs[ra];
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (we && wa != '0) begin
      regs[wa] <= wd;
    end
    if (!hold) begin
      rd1 <= read_port(ra1);
      rd2 <= read_port(ra2);
    end
  end

endmodule

`default_nettype wire

// File: design/decode_read.sv
`timescale 1ns/1ps
`default_nettype none

module decode_read (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  rv_pkg::word_t   instr,
  input  wire  rv_pkg::word_t   fetch_pc,
  input  wire                   internal_stall,
  input  wire                   bubble,
  output rv_pkg::reg_idx_t      rs1_addr,
  output rv_pkg::reg_idx_t      rs2_addr,
  decode_bus_if.stage1          bus
);

  rv_pkg::word_t    ir;
  logic [6:0]       opcode;
  rv_pkg::funct3_t  funct3;
  rv_pkg::reg_idx_t rd;
  logic             alt;
  rv_pkg::word_t    imm_i;
  rv_pkg::word_t    imm_s;
  rv_pkg::word_t    imm_b;
  rv_pkg::word_t    imm_u;
  rv_pkg::word_t    imm_j;
  rv_pkg::word_t    imm;
  rv_pkg::alu_op_t  alu_op;
  logic             a_sel;
  logic             b_sel;
  logic             is_jump;
  logic             is_branch;
  logic             writes_rd;
  logic             mem_we;
  logic             mem_rr;
  logic             csr_write;

  function automatic rv_pkg::alu_op_t alu_from_funct(input rv_pkg::funct3_t f3,
                                                     input logic sub_or_sra);
    rv_pkg::alu_op_t op;
    case (f3)
      rv_pkg::f3_add:  op = sub_or_sra ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:  op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:  op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu: op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:  op = rv_pkg::alu_xor;
      rv_pkg::f3_sr:   op = sub_or_sra ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:   op = rv_pkg::alu_or;
      rv_pkg::f3_and:  op = rv_pkg::alu_and;
      default:         op = rv_pkg::alu_add;
    endcase
    return op;
  endfunction

  // A squashed instruction is decoded as a NOP, which raises no flags.
  assign ir       = bubble ? rv_pkg::nop_instr : instr;
  assign opcode   = ir[6:0];
  assign funct3   = ir[14:12];
  assign rd       = ir[11:7];
  assign rs1_addr = ir[19:15];
  assign rs2_addr = ir[24:20];

  // Bit 30 only means SUB for register ops; for immediates it matters on right shifts.
  assign alt = ir[30] && (opcode == rv_pkg::op_reg || funct3 == rv_pkg::f3_sr);

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  always_comb begin
    alu_op    = rv_pkg::alu_add;
    a_sel     = 1'b0;
    b_sel     = 1'b1;
    imm       = imm_i;
    is_jump   = 1'b0;
    is_branch = 1'b0;
    writes_rd = 1'b0;
    mem_we    = 1'b0;
    mem_rr    = 1'b0;
    csr_write = 1'b0;
    case (opcode)
      rv_pkg::op_lui: begin
        alu_op    = rv_pkg::alu_copy_b;
        imm       = imm_u;
        writes_rd = 1'b1;
      end
      rv_pkg::op_auipc: begin
        a_sel     = 1'b1;
        imm       = imm_u;
        writes_rd = 1'b1;
      end
      rv_pkg::op_jal: begin
        a_sel     = 1'b1;
        imm       = imm_j;
        is_jump   = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_jalr: begin
        is_jump   = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_branch: begin
        a_sel     = 1'b1;
        imm       = imm_b;
        is_branch = 1'b1;
      end
      rv_pkg::op_load: begin
        mem_rr    = 1'b1;
        writes_rd = 1'b1;
      end
      rv_pkg::op_store: begin
        imm    = imm_s;
        mem_we = 1'b1;
      end
      rv_pkg::op_imm: begin
        alu_op    = alu_from_funct(funct3, alt);
        writes_rd = 1'b1;
      end
      rv_pkg::op_reg: begin
        alu_op    = alu_from_funct(funct3, alt);
        b_sel     = 1'b0;
        writes_rd = 1'b1;
      end
      rv_pkg::op_system: begin
        // CSRRW passes rs1 through the adder with a zero immediate.
        imm       = '0;
        csr_write = (funct3 == rv_pkg::f3_csrrw) && (ir[31:20] == rv_pkg::csr_tohost);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.is_jump   <= 1'b0;
      bus.is_branch <= 1'b0;
      bus.reg_we    <= 1'b0;
      bus.mem_we    <= 1'b0;
      bus.mem_rr    <= 1'b0;
      bus.csr_write <= 1'b0;
    end else if (!internal_stall) begin
      bus.is_jump   <= is_jump;
      bus.is_branch <= is_branch;
      bus.reg_we    <= writes_rd && (rd != '0);
      bus.mem_we    <= mem_we;
      bus.mem_rr    <= mem_rr;
      bus.csr_write <= csr_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!internal_stall) begin
      bus.pc     <= fetch_pc;
      bus.imm    <= imm;
      bus.alu_op <= alu_op;
      bus.funct3 <= funct3;
      bus.rs1    <= rs1_addr;
      bus.rs2    <= rs2_addr;
      bus.rd     <= rd;
      bus.a_sel  <= a_sel;
      bus.b_sel  <= b_sel;
    end
  end

endmodule

`default_nettype wire

// File: design/decode_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Stage 1 to stage 2 fields, registered in decode_read.
interface decode_bus_if;
  rv_pkg::word_t    pc;
  rv_pkg::word_t    imm;
  rv_pkg::alu_op_t  alu_op;
  rv_pkg::funct3_t  funct3;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  logic             a_sel;
  logic             b_sel;
  logic             is_jump;
  logic             is_branch;
  logic             reg_we;
  logic             mem_we;
  logic             mem_rr;
  logic             csr_write;

  modport stage1 (
    output pc, imm, alu_op, funct3, rs1, rs2, rd, a_sel, b_sel,
    output is_jump, is_branch, reg_we, mem_we, mem_rr, csr_write
  );
  modport stage2 (
    input pc, imm, alu_op, funct3, rs1, rs2, rd, a_sel, b_sel,
    input is_jump, is_branch, reg_we, mem_we, mem_rr, csr_write
  );
endinterface

// Stage 2 to stage 3 fields, registered in execute.
interface exec_bus_if;
  rv_pkg::word_t    result;
  rv_pkg::word_t    store_data;
  rv_pkg::funct3_t  funct3;
  rv_pkg::reg_idx_t rd;
  logic             reg_we;
  logic             mem_we;
  logic             mem_rr;
  logic             csr_write;
  logic             do_jump;

  modport stage2 (
    output result, store_data, funct3, rd,
    output reg_we, mem_we, mem_rr, csr_write, do_jump
  );
  modport stage3 (
    input result, store_data, funct3, rd,
    input reg_we, mem_we, mem_rr, csr_write, do_jump
  );
endinterface

`default_nettype wire

// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Core widths.
  localparam int xlen = 32;
  localparam int reg_count = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [$clog2(reg_count)-1:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [3:0] byte_en_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_copy_b
  } alu_op_t;

  // Major opcodes of the supported RV32I subset.
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // ALU funct3 codes. Instruction bit 30 picks SUB or SRA.
  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // Branch conditions.
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // Access sizes shared by loads and stores.
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;

  localparam funct3_t     f3_csrrw   = 3'b001;
  localparam logic [11:0] csr_tohost = 12'h51e;

  localparam word_t reset_pc  = 32'h0000_0000;
  localparam word_t nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire
